// ==== verilog/delay_settings.svh ====
`ifndef DELAY_SETTINGS_SVH
`define DELAY_SETTINGS_SVH

// Payload width of one stream item
`define DATA_W 8

// Entries per lane FIFO, power of two
// One slot stays free so a lane holds FIFO_DEPTH-1 items
`define FIFO_DEPTH 16

// Free-running timer and stamp width
`define TIME_W 16

// Release delay per lane, in cycles
`define LANE0_DELAY 4
`define LANE1_DELAY 9

`endif

// ==== verilog/delay_pkg.sv ====
package delay_pkg;

    // Lane number on the merged output
    typedef logic lane_t;

    // Merger grant states
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,  // No packet in flight
        ARB_LANE0 = 2'd1,  // Lane 0 holds the output
        ARB_LANE1 = 2'd2   // Lane 1 holds the output
    } arb_state_e;

endpackage

// ==== verilog/stream_if.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

interface stream_if;

    logic              valid;  // Source has an item
    logic              ready;  // Sink takes it this cycle
    logic [`DATA_W-1:0] data;
    logic              last;   // Final item of a packet

    // Producer side
    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    // Consumer side
    modport snk (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// ==== verilog/fifo_fwft.sv ====
`timescale 1ns/10ps

module fifo_fwft #(
    parameter int DEPTH = 16,  // Must be a power of two
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             srst,
    // Write side
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    // Read side, head always visible
    output logic             empty,
    output logic [WIDTH-1:0] dout,
    input  logic             rd_en
);

    localparam int PW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    logic [PW-1:0]    head;      // Next entry to leave
    logic [PW-1:0]    tail;      // Next free slot
    logic [PW-1:0]    tail_inc;
    logic             do_wr;
    logic             do_rd;

    assign tail_inc = tail + 1'b1;

    // One slot kept free to tell full from empty
    assign full  = (tail_inc == head);
    assign empty = (head == tail);

    assign do_wr = wr_en && !full;   // Writes past full are ignored
    assign do_rd = rd_en && !empty;

    // Storage write at the tail slot
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[tail] <= din;
        end
    end

    // Tail advances on each accepted write
    always_ff @(posedge clk) begin
        if (srst) begin
            tail <= '0;
        end else if (do_wr) begin
            tail <= tail_inc;
        end
    end

    // Head advances on each pop
    always_ff @(posedge clk) begin
        if (srst) begin
            head <= '0;
        end else if (do_rd) begin
            head <= head + 1'b1;
        end
    end

    // Fall-through read
    assign dout = mem[head];

endmodule

// ==== verilog/delay_stage.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

module delay_stage #(
    parameter int DELAY = 1  // Minimum residence in cycles
) (
    input  logic               clk,
    input  logic               srst,
    // Incoming lane
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [`DATA_W-1:0] in_data,
    input  logic               in_last,
    // Delayed lane
    stream_if.src              out
);

    localparam int ENTRY_W = `DATA_W + 1 + `TIME_W;  // last, data, stamp

    logic [`TIME_W-1:0] timer;       // Free-running cycle count
    logic [ENTRY_W-1:0] wr_entry;
    logic [ENTRY_W-1:0] head_entry;
    logic [`TIME_W-1:0] head_stamp;
    logic [`TIME_W-1:0] head_age;
    logic               fifo_full;
    logic               fifo_empty;
    logic               released;    // Head old enough to leave
    logic               pop;

    // Timer wraps freely, ages use modular difference
    always_ff @(posedge clk) begin
        if (srst) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // Stamp is the timer value just after the accepting edge
    assign wr_entry = {in_last, in_data, timer + 1'b1};

    fifo_fwft #(
        .DEPTH (`FIFO_DEPTH),
        .WIDTH (ENTRY_W)
    ) u_fifo (
        .clk   (clk),
        .srst  (srst),
        .wr_en (in_valid),
        .din   (wr_entry),
        .full  (fifo_full),
        .empty (fifo_empty),
        .dout  (head_entry),
        .rd_en (pop)
    );

    assign in_ready = !fifo_full;  // Drops at FIFO_DEPTH-1 items

    // Split the head word
    assign head_stamp = head_entry[`TIME_W-1:0];
    assign head_age   = timer - head_stamp;  // Wraps cleanly

    // Age equals DELAY from edge t+DELAY onwards
    assign released = !fifo_empty && (head_age >= `TIME_W'(DELAY));

    assign out.valid = released;
    assign out.data  = head_entry[`TIME_W +: `DATA_W];
    assign out.last  = head_entry[ENTRY_W-1];

    // Held-back head cannot be popped
    assign pop = released && out.ready;

endmodule

// ==== verilog/packet_merger.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

module packet_merger (
    input  logic                clk,
    input  logic                srst,
    // Delayed lanes
    stream_if.snk               lane0,
    stream_if.snk               lane1,
    // Merged output
    output logic                out_valid,
    input  logic                out_ready,
    output logic [`DATA_W-1:0]  out_data,
    output logic                out_last,
    output delay_pkg::lane_t    out_lane
);

    delay_pkg::arb_state_e state;        // Grant register
    delay_pkg::lane_t      last_served;  // Lane of the last finished packet
    delay_pkg::lane_t      sel;          // Lane currently routed
    logic                  sel_active;   // A lane holds or wins the grant
    logic                  sel_valid;
    logic                  xfer;

    // Grant decision, purely combinational
    always_comb begin
        sel        = 1'b0;
        sel_active = 1'b0;
        case (state)
            delay_pkg::ARB_LANE0: begin
                sel        = 1'b0;  // Locked mid-packet
                sel_active = 1'b1;
            end
            delay_pkg::ARB_LANE1: begin
                sel        = 1'b1;
                sel_active = 1'b1;
            end
            default: begin
                // Both waiting, favour the lane not served last
                if (lane0.valid && lane1.valid) begin
                    sel        = ~last_served;
                    sel_active = 1'b1;
                end else if (lane1.valid) begin
                    sel        = 1'b1;
                    sel_active = 1'b1;
                end else if (lane0.valid) begin
                    sel        = 1'b0;
                    sel_active = 1'b1;
                end
            end
        endcase
    end

    // Output mux
    assign sel_valid = sel ? lane1.valid : lane0.valid;
    assign out_valid = sel_active && sel_valid;
    assign out_data  = sel ? lane1.data : lane0.data;
    assign out_last  = sel ? lane1.last : lane0.last;
    assign out_lane  = sel;

    // Only the granted lane sees ready
    assign lane0.ready = sel_active && (sel == 1'b0) && out_ready;
    assign lane1.ready = sel_active && (sel == 1'b1) && out_ready;

    assign xfer = out_valid && out_ready;

    // Lock on first valid item, release after last transfers
    always_ff @(posedge clk) begin
        if (srst) begin
            state       <= delay_pkg::ARB_IDLE;
            last_served <= 1'b1;  // Lane 0 goes first
        end else begin
            if (xfer && out_last) begin
                state       <= delay_pkg::ARB_IDLE;
                last_served <= sel;
            end else if (state == delay_pkg::ARB_IDLE && out_valid) begin
                // Hold the choice even when stalled
                state <= sel ? delay_pkg::ARB_LANE1 : delay_pkg::ARB_LANE0;
            end
        end
    end

endmodule

// ==== verilog/delay_merge_top.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

module delay_merge_top (
    input  logic                clk,
    input  logic                srst,
    // Lane 0 input
    input  logic                in0_valid,
    output logic                in0_ready,
    input  logic [`DATA_W-1:0]  in0_data,
    input  logic                in0_last,
    // Lane 1 input
    input  logic                in1_valid,
    output logic                in1_ready,
    input  logic [`DATA_W-1:0]  in1_data,
    input  logic                in1_last,
    // Merged output
    output logic                out_valid,
    input  logic                out_ready,
    output logic [`DATA_W-1:0]  out_data,
    output logic                out_last,
    output delay_pkg::lane_t    out_lane
);

    // Delayed lanes into the merger
    stream_if lane0_s ();
    stream_if lane1_s ();

    // Lane 0, short delay
    delay_stage #(
        .DELAY (`LANE0_DELAY)
    ) u_stage0 (
        .clk      (clk),
        .srst     (srst),
        .in_valid (in0_valid),
        .in_ready (in0_ready),
        .in_data  (in0_data),
        .in_last  (in0_last),
        .out      (lane0_s.src)
    );

    // Lane 1, long delay
    delay_stage #(
        .DELAY (`LANE1_DELAY)
    ) u_stage1 (
        .clk      (clk),
        .srst     (srst),
        .in_valid (in1_valid),
        .in_ready (in1_ready),
        .in_data  (in1_data),
        .in_last  (in1_last),
        .out      (lane1_s.src)
    );

    // Packet-aware round robin, zero latency
    packet_merger u_merger (
        .clk       (clk),
        .srst      (srst),
        .lane0     (lane0_s.snk),
        .lane1     (lane1_s.snk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_lane  (out_lane)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    // Free-running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// ==== bench/delay_merge_assertions.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

module delay_merge_assertions (
    input logic               clk,
    input logic               srst,
    input logic               out_valid,
    input logic               out_ready,
    input logic [`DATA_W-1:0] out_data,
    input logic               out_last,
    input delay_pkg::lane_t   out_lane
);

    logic             mid_pkt;   // Packet started but last not yet sent
    delay_pkg::lane_t pkt_lane;  // Lane owning that packet

    always_ff @(posedge clk) begin
        if (srst) begin
            mid_pkt  <= 1'b0;
            pkt_lane <= 1'b0;
        end else if (out_valid && out_ready) begin
            mid_pkt  <= !out_last;
            pkt_lane <= out_lane;
        end
    end

    // Stalled output holds its whole beat
    stall_hold: assert property (@(posedge clk) disable iff (srst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_last) && $stable(out_lane)))
        else $error("merged output changed while stalled");

    // No lane switch inside a packet
    lane_locked: assert property (@(posedge clk) disable iff (srst)
        (out_valid && mid_pkt) |-> (out_lane == pkt_lane))
        else $error("out_lane switched before the packet ended");

endmodule

bind delay_merge_top delay_merge_assertions u_assertions (
    .clk       (clk),
    .srst      (srst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_lane  (out_lane)
);

// ==== bench/delay_merge_tb.sv ====
`timescale 1ns/10ps
`include "delay_settings.svh"

module delay_merge_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int FULL_LEVEL  = `FIFO_DEPTH - 1;   // Items one lane can hold
    localparam int DLY0        = `LANE0_DELAY;
    localparam int DLY1        = `LANE1_DELAY;
    localparam int RAND_ITEMS  = 60;                // Per lane in the random phase
    localparam int TOTAL_ITEMS = 2 + 2 * (FULL_LEVEL + 1) + 2 * RAND_ITEMS;
    localparam int CYCLE_LIMIT = 20 * TOTAL_ITEMS + 500;
    localparam int ENT_W       = 1 + `DATA_W + 32;  // last, data, accept cycle

    logic               clk;
    logic               srst;
    logic               in0_valid;
    logic               in0_ready;
    logic [`DATA_W-1:0] in0_data;
    logic               in0_last;
    logic               in1_valid;
    logic               in1_ready;
    logic [`DATA_W-1:0] in1_data;
    logic               in1_last;
    logic               out_valid;
    logic               out_ready;
    logic [`DATA_W-1:0] out_data;
    logic               out_last;
    delay_pkg::lane_t   out_lane;

    logic               drv_valid [2];   // Next values for the lane inputs
    logic [`DATA_W-1:0] drv_data [2];
    logic               drv_last [2];
    logic               drv_ready;
    logic               acc [2];         // Taken at the last edge
    logic               rdy_s [2];       // in_ready just before the edge
    int                 items_left [2];  // Still to generate
    int                 pkt_left [2];
    int                 acc_total [2];
    int                 occ [2];         // Accepted minus delivered
    logic [ENT_W-1:0]   q0 [$];          // Reference queues per lane
    logic [ENT_W-1:0]   q1 [$];
    logic               in_pkt;
    logic               pkt_lane;
    logic               exact_latency;   // Directed phase, latency must equal delay
    logic               expect_idle;
    int                 cycle = 0;
    int                 seed;
    int                 err_count;
    int                 tests_run;
    int                 tests_failed;
    int                 start;
    int                 base0;
    int                 base1;
    int                 guard;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    delay_merge_top dut_i (
        .clk       (clk),
        .srst      (srst),
        .in0_valid (in0_valid),
        .in0_ready (in0_ready),
        .in0_data  (in0_data),
        .in0_last  (in0_last),
        .in1_valid (in1_valid),
        .in1_ready (in1_ready),
        .in1_data  (in1_data),
        .in1_last  (in1_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_lane  (out_lane)
    );

    // Edge counter doubles as the watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with items still in flight", cycle);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic value_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
        err_count++;
    endtask

    task automatic plain_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic check_ready(input bit l);
        logic exp_rdy;
        exp_rdy = (occ[l] < FULL_LEVEL);  // Full at FIFO_DEPTH-1 items
        if (rdy_s[l] !== exp_rdy) begin
            value_mismatch(l ? "in1_ready" : "in0_ready", 32'(rdy_s[l]), 32'(exp_rdy));
        end
    endtask

    task automatic take_output();
        bit               l;
        int               dly;
        int               lat;
        logic [ENT_W-1:0] ent;
        l   = out_lane;
        dly = l ? DLY1 : DLY0;
        if ((!l && q0.size() == 0) || (l && q1.size() == 0)) begin
            plain_failure($sformatf("lane %0d delivered an item it never accepted", l));
        end else begin
            if (l) begin
                ent = q1.pop_front();
            end else begin
                ent = q0.pop_front();
            end
            lat = cycle - int'(ent[31:0]) - 1;  // Accept edge to the cycle it is seen
            if (out_data !== ent[ENT_W-2 -: `DATA_W]) begin
                value_mismatch("out_data", 32'(out_data), 32'(ent[ENT_W-2 -: `DATA_W]));
            end
            if (out_last !== ent[ENT_W-1]) begin
                value_mismatch("out_last", 32'(out_last), 32'(ent[ENT_W-1]));
            end
            if (lat < dly || (exact_latency && lat != dly)) begin
                plain_failure($sformatf("lane %0d item left after %0d cycles, delay is %0d",
                                        l, lat, dly));
            end
            occ[l]--;
        end
        if (in_pkt && out_lane != pkt_lane) begin
            value_mismatch("out_lane", 32'(out_lane), 32'(pkt_lane));
        end
        in_pkt   = !out_last;  // Packet open until last
        pkt_lane = out_lane;
    endtask

    task automatic accept_input(input bit l);
        acc[l] = drv_valid[l] && rdy_s[l];
        if (acc[l]) begin
            if (l) begin
                q1.push_back({drv_last[1], drv_data[1], cycle});
            end else begin
                q0.push_back({drv_last[0], drv_data[0], cycle});
            end
            occ[l]++;
            acc_total[l]++;
        end
    endtask

    // Called just ahead of the rising edge, outputs settled
    task automatic sample_and_check();
        rdy_s[0] = in0_ready;
        rdy_s[1] = in1_ready;
        if (expect_idle && out_valid !== 1'b0) begin
            value_mismatch("out_valid", 32'(out_valid), 32'd0);
        end
        check_ready(1'b0);
        check_ready(1'b1);
        if (out_valid === 1'b1 && out_ready === 1'b1) begin
            take_output();
        end
        accept_input(1'b0);
        accept_input(1'b1);
    endtask

    // One clock: drive on the falling edge, check before the rising one
    task automatic tick();
        @(negedge clk);
        in0_valid = drv_valid[0];
        in0_data  = drv_data[0];
        in0_last  = drv_last[0];
        in1_valid = drv_valid[1];
        in1_data  = drv_data[1];
        in1_last  = drv_last[1];
        out_ready = drv_ready;
        #(CLK_PERIOD / 2 - 1);
        sample_and_check();
        @(posedge clk);
    endtask

    // Holds a pending item until taken, else maybe starts a new one
    task automatic next_item(input bit l, input int valid_pct);
        int len;
        if (drv_valid[l] && !acc[l]) begin
            drv_valid[l] = 1'b1;
        end else if (items_left[l] > 0 && rand_below(100) < valid_pct) begin
            if (pkt_left[l] == 0) begin
                len         = 1 + rand_below(6);
                pkt_left[l] = (len < items_left[l]) ? len : items_left[l];
            end
            drv_valid[l] = 1'b1;
            drv_data[l]  = `DATA_W'(rand_below(256));
            drv_last[l]  = (pkt_left[l] == 1);
            pkt_left[l]--;
            items_left[l]--;
        end else begin
            drv_valid[l] = 1'b0;
        end
    endtask

    task automatic run_until_idle(input int valid_pct, input int ready_pct);
        while (items_left[0] > 0 || items_left[1] > 0 || drv_valid[0] || drv_valid[1] ||
               occ[0] > 0 || occ[1] > 0) begin
            next_item(1'b0, valid_pct);
            next_item(1'b1, valid_pct);
            drv_ready = (rand_below(100) < ready_pct);
            tick();
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (err_count == err_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_count - err_start);
        end
    endtask

    initial begin
        seed          = 32'hb48c;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        in_pkt        = 1'b0;
        pkt_lane      = 1'b0;
        exact_latency = 1'b0;
        expect_idle   = 1'b0;
        drv_ready     = 1'b0;
        for (int i = 0; i < 2; i++) begin
            drv_valid[i]  = 1'b0;
            drv_data[i]   = '0;
            drv_last[i]   = 1'b0;
            acc[i]        = 1'b0;
            rdy_s[i]      = 1'b1;
            items_left[i] = 0;
            pkt_left[i]   = 0;
            acc_total[i]  = 0;
            occ[i]        = 0;
        end
        srst      = 1'b1;
        in0_valid = 1'b0;
        in0_data  = '0;
        in0_last  = 1'b0;
        in1_valid = 1'b0;
        in1_data  = '0;
        in1_last  = 1'b0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        srst = 1'b0;

        start       = err_count;  // Idle output, both lanes ready
        expect_idle = 1'b1;
        repeat (4) tick();
        expect_idle = 1'b0;
        finish_test("reset state", start);

        start         = err_count;  // Single item per lane, exact latency
        exact_latency = 1'b1;
        items_left[0] = 1;
        run_until_idle(100, 100);
        items_left[1] = 1;
        run_until_idle(100, 100);
        exact_latency = 1'b0;
        finish_test("lane latency", start);

        start         = err_count;  // Output stalled until both lanes fill
        base0         = acc_total[0];
        base1         = acc_total[1];
        items_left[0] = FULL_LEVEL + 1;
        items_left[1] = FULL_LEVEL + 1;
        guard         = 0;
        while ((rdy_s[0] || rdy_s[1]) && guard < 3 * FULL_LEVEL) begin
            next_item(1'b0, 100);
            next_item(1'b1, 100);
            drv_ready = 1'b0;
            tick();
            guard++;
        end
        if (rdy_s[0] || rdy_s[1]) begin
            plain_failure("in_ready stayed high with the output stalled");
        end
        if (acc_total[0] - base0 != FULL_LEVEL || acc_total[1] - base1 != FULL_LEVEL) begin
            plain_failure($sformatf("lanes took %0d and %0d items before filling, not %0d",
                                    acc_total[0] - base0, acc_total[1] - base1, FULL_LEVEL));
        end
        run_until_idle(100, 100);
        finish_test("back-pressure", start);

        start         = err_count;  // Random packets, valid and ready toggling
        items_left[0] = RAND_ITEMS;
        items_left[1] = RAND_ITEMS;
        run_until_idle(70, 75);
        drv_ready     = 1'b1;       // Lanes drained, nothing more may appear
        expect_idle   = 1'b1;
        repeat (DLY1 + 2) tick();
        expect_idle   = 1'b0;
        finish_test("random traffic", start);

        $display("Summary: %0d tests, %0d failed, %0d error lines",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/delay_pkg.sv
verilog/stream_if.sv
verilog/fifo_fwft.sv
verilog/delay_stage.sv
verilog/packet_merger.sv
verilog/delay_merge_top.sv
bench/tb_clock.sv
bench/delay_merge_assertions.sv
bench/delay_merge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the delay/merge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module delay_merge_tb \
    -Mdir obj_dir

# A fired assertion stops the simulator with a non-zero status
sim_out=$(./obj_dir/Vdelay_merge_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
